// ==== controlPkg.sv ====
`default_nettype none

package controlPkg;

    ////////////////////
    // FSM states
    ////////////////////
    typedef enum logic [4:0] {
        stResetInit,      // Stack pointer load
        stFetchWait,      // Instruction memory latency
        stFetchLatch,     // IR load and PC + 4
        stDecode,
        stAluExec,
        stWriteBack,      // R and I type result to register file
        stBranchTarget,
        stBranchCompare,
        stAddrCalc,       // Base + offset for lw and sw
        stMemRead,
        stLoadWrite,
        stStore,
        stJump,           // Shared by j and jal
        stExceptOverflow,
        stExceptInvalid   // Keep last, range check depends on it
    } stateT;

    typedef enum logic [4:0] {
        clsAdd, clsSub, clsAnd, clsOr, clsSlt,
        clsAddi, clsAddiu, clsSlti,
        clsBeq, clsBne, clsBle, clsBgt,
        clsLw, clsSw,
        clsJ, clsJal,
        clsInvalid
    } instrClassT;

    // ALU function codes as the datapath ALU expects them
    typedef enum logic [4:0] {
        aluLoad    = 5'd0,
        aluAddOv   = 5'd1,  // Add, overflow flagged
        aluSub     = 5'd2,
        aluAnd     = 5'd3,
        aluCmp     = 5'd7,  // Set on less than
        aluOr      = 5'd8,
        aluAddNoOv = 5'd11,
        aluNe      = 5'd14,
        aluEq      = 5'd15,
        aluLe      = 5'd16,
        aluGt      = 5'd17
    } aluOpT;

    typedef enum logic [1:0] {srcBRegB, srcBFour, srcBImm, srcBBranchOff} aluSrcBT;
    typedef enum logic [1:0] {mtrAluOut, mtrMemData, mtrStackInit, mtrPcLink} memToRegT;
    typedef enum logic [1:0] {dstRt, dstRd, dstReturnAddr, dstStackPtr} regDestT;
    typedef enum logic [1:0] {
        pcsJumpTarget, pcsAluResult, pcsAluOut, pcsExceptionVector
    } pcSourceT;
    typedef enum logic [1:0] {excNone, excInvalid, excOverflow} excCauseT;

    ////////////////////
    // Instruction codes
    ////////////////////
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_ADDI  = 6'h08;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_SLTI  = 6'h0a;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;
    localparam logic [5:0] OP_BLE   = 6'h06;
    localparam logic [5:0] OP_BGT   = 6'h07;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;
    localparam logic [5:0] OP_J     = 6'h02;
    localparam logic [5:0] OP_JAL   = 6'h03;

    localparam logic [5:0] FN_ADD   = 6'h20;  // Funct field, R-type only
    localparam logic [5:0] FN_SUB   = 6'h22;
    localparam logic [5:0] FN_AND   = 6'h24;
    localparam logic [5:0] FN_OR    = 6'h25;
    localparam logic [5:0] FN_SLT   = 6'h2a;

endpackage

`default_nettype wire

// ==== instrDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
    input  wire [5:0]             opcode,
    input  wire [5:0]             funct,
    output controlPkg::instrClassT instrClass
);

    always_comb
    begin
        case (opcode)
            controlPkg::OP_RTYPE:
            begin
                case (funct)
                    controlPkg::FN_ADD: instrClass = controlPkg::clsAdd;
                    controlPkg::FN_SUB: instrClass = controlPkg::clsSub;
                    controlPkg::FN_AND: instrClass = controlPkg::clsAnd;
                    controlPkg::FN_OR:  instrClass = controlPkg::clsOr;
                    controlPkg::FN_SLT: instrClass = controlPkg::clsSlt;
                    default:            instrClass = controlPkg::clsInvalid;  // Shifts, mult etc
                endcase
            end

            // Immediate arithmetic
            controlPkg::OP_ADDI:  instrClass = controlPkg::clsAddi;
            controlPkg::OP_ADDIU: instrClass = controlPkg::clsAddiu;
            controlPkg::OP_SLTI:  instrClass = controlPkg::clsSlti;

            controlPkg::OP_BEQ:   instrClass = controlPkg::clsBeq;
            controlPkg::OP_BNE:   instrClass = controlPkg::clsBne;
            controlPkg::OP_BLE:   instrClass = controlPkg::clsBle;
            controlPkg::OP_BGT:   instrClass = controlPkg::clsBgt;

            controlPkg::OP_LW:    instrClass = controlPkg::clsLw;  // Word access only
            controlPkg::OP_SW:    instrClass = controlPkg::clsSw;

            controlPkg::OP_J:     instrClass = controlPkg::clsJ;
            controlPkg::OP_JAL:   instrClass = controlPkg::clsJal;

            default:              instrClass = controlPkg::clsInvalid;
        endcase
    end

endmodule

`default_nettype wire

// ==== stateSequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module stateSequencer #(
    parameter int memWaitCycles = 2
) (
    input  wire                    clk,
    input  wire                    reset,
    input  wire controlPkg::instrClassT instrClass,
    input  wire                    overflowFlag,
    output controlPkg::stateT      state,
    output controlPkg::instrClassT latchedClass
);

    localparam int cntW = $clog2(memWaitCycles + 1);
    localparam logic [cntW-1:0] lastCnt = cntW'(memWaitCycles - 1);

    controlPkg::stateT stateNext;
    logic [cntW-1:0]   waitCnt;
    logic              waitState;
    logic              waitDone;
    logic              ovfClass;

    assign waitState = (state == controlPkg::stFetchWait) || (state == controlPkg::stMemRead);
    assign waitDone  = (waitCnt == lastCnt);
    assign ovfClass  = latchedClass inside
        {controlPkg::clsAdd, controlPkg::clsSub, controlPkg::clsAddi};

    ////////////////////
    // Registers
    ////////////////////
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state        <= controlPkg::stResetInit;
            waitCnt      <= '0;
            latchedClass <= controlPkg::clsInvalid;
        end
        else
        begin
            state <= stateNext;
            if (waitState && !waitDone)
                waitCnt <= waitCnt + cntW'(1);
            else
                waitCnt <= '0;  // Back to zero for the next wait state
            if (state == controlPkg::stDecode)
                latchedClass <= instrClass;  // IR fields stable during decode
        end
    end

    ////////////////////
    // Next state
    ////////////////////
    always_comb
    begin
        case (state)
            controlPkg::stResetInit: stateNext = controlPkg::stFetchWait;
            controlPkg::stFetchWait:
                stateNext = waitDone ? controlPkg::stFetchLatch : controlPkg::stFetchWait;
            controlPkg::stFetchLatch: stateNext = controlPkg::stDecode;
            controlPkg::stDecode:
            begin
                // Class is captured on this same edge
                case (instrClass)
                    controlPkg::clsAdd, controlPkg::clsSub, controlPkg::clsAnd,
                    controlPkg::clsOr, controlPkg::clsSlt, controlPkg::clsAddi,
                    controlPkg::clsAddiu, controlPkg::clsSlti:
                        stateNext = controlPkg::stAluExec;
                    controlPkg::clsBeq, controlPkg::clsBne, controlPkg::clsBle,
                    controlPkg::clsBgt:
                        stateNext = controlPkg::stBranchTarget;
                    controlPkg::clsLw, controlPkg::clsSw:
                        stateNext = controlPkg::stAddrCalc;
                    controlPkg::clsJ, controlPkg::clsJal:
                        stateNext = controlPkg::stJump;
                    default:
                        stateNext = controlPkg::stExceptInvalid;
                endcase
            end
            controlPkg::stAluExec:
                stateNext = (overflowFlag && ovfClass) ? controlPkg::stExceptOverflow
                                                       : controlPkg::stWriteBack;
            controlPkg::stBranchTarget: stateNext = controlPkg::stBranchCompare;
            controlPkg::stAddrCalc:
                stateNext = (latchedClass == controlPkg::clsLw) ? controlPkg::stMemRead
                                                                : controlPkg::stStore;
            controlPkg::stMemRead:
                stateNext = waitDone ? controlPkg::stLoadWrite : controlPkg::stMemRead;
            default: stateNext = controlPkg::stFetchWait;  // All 1-cycle tails refetch
        endcase
    end

    ////////////////////
    // Checks
    ////////////////////
    waitCntBound: assert property (@(posedge clk) disable iff (reset)
        int'(waitCnt) <= memWaitCycles)
        else $error("Wait counter above memWaitCycles");

    stateLegal: assert property (@(posedge clk) disable iff (reset)
        state <= controlPkg::stExceptInvalid)
        else $error("State outside the FSM encoding");

endmodule

`default_nettype wire

// ==== controlSignalDecode.sv ====
`timescale 1ns/1ps
`default_nettype none

module controlSignalDecode (
    input  wire controlPkg::stateT      state,
    input  wire controlPkg::instrClassT latchedClass,
    output logic                        pcWrite,
    output logic                        pcWriteCond,
    output logic                        iOrD,
    output logic                        memWrite,
    output logic                        irWrite,
    output logic                        regWrite,
    output logic                        aluSrcA,
    output logic                        epcWrite,
    output controlPkg::regDestT         regDest,
    output controlPkg::memToRegT        memToReg,
    output controlPkg::aluSrcBT         aluSrcB,
    output controlPkg::aluOpT           aluControl,
    output controlPkg::pcSourceT        pcSource,
    output controlPkg::excCauseT        excCause
);

    logic immClass;

    assign immClass = latchedClass inside
        {controlPkg::clsAddi, controlPkg::clsAddiu, controlPkg::clsSlti};

    always_comb
    begin
        // Idle values
        pcWrite     = 1'b0;
        pcWriteCond = 1'b0;
        iOrD        = 1'b0;
        memWrite    = 1'b0;
        irWrite     = 1'b0;
        regWrite    = 1'b0;
        aluSrcA     = 1'b0;
        epcWrite    = 1'b0;
        regDest     = controlPkg::dstRt;
        memToReg    = controlPkg::mtrAluOut;
        aluSrcB     = controlPkg::srcBRegB;
        aluControl  = controlPkg::aluLoad;
        pcSource    = controlPkg::pcsJumpTarget;
        excCause    = controlPkg::excNone;

        case (state)
            controlPkg::stResetInit:
            begin
                regWrite = 1'b1;
                regDest  = controlPkg::dstStackPtr;
                memToReg = controlPkg::mtrStackInit;  // Initial stack top
            end
            controlPkg::stFetchLatch:
            begin
                irWrite    = 1'b1;
                aluSrcB    = controlPkg::srcBFour;  // PC + 4
                aluControl = controlPkg::aluAddOv;
            end
            controlPkg::stDecode:
            begin
                pcWrite  = 1'b1;
                pcSource = controlPkg::pcsAluOut;
            end
            controlPkg::stAluExec:
            begin
                aluSrcA = 1'b1;
                aluSrcB = immClass ? controlPkg::srcBImm : controlPkg::srcBRegB;
                case (latchedClass)
                    controlPkg::clsSub:   aluControl = controlPkg::aluSub;
                    controlPkg::clsAnd:   aluControl = controlPkg::aluAnd;
                    controlPkg::clsOr:    aluControl = controlPkg::aluOr;
                    controlPkg::clsSlt,
                    controlPkg::clsSlti:  aluControl = controlPkg::aluCmp;
                    controlPkg::clsAddiu: aluControl = controlPkg::aluAddNoOv;
                    default:              aluControl = controlPkg::aluAddOv;  // add, addi
                endcase
            end
            controlPkg::stWriteBack:
            begin
                regWrite = 1'b1;
                regDest  = immClass ? controlPkg::dstRt : controlPkg::dstRd;
            end
            controlPkg::stBranchTarget:
            begin
                aluSrcB    = controlPkg::srcBBranchOff;
                aluControl = controlPkg::aluAddOv;
            end
            controlPkg::stBranchCompare:
            begin
                pcWriteCond = 1'b1;
                pcSource    = controlPkg::pcsAluOut;  // Target from previous cycle
                case (latchedClass)
                    controlPkg::clsBne: aluControl = controlPkg::aluNe;
                    controlPkg::clsBle: aluControl = controlPkg::aluLe;
                    controlPkg::clsBgt: aluControl = controlPkg::aluGt;
                    default:            aluControl = controlPkg::aluEq;
                endcase
            end
            controlPkg::stAddrCalc:
            begin
                aluSrcA    = 1'b1;
                aluSrcB    = controlPkg::srcBImm;
                aluControl = controlPkg::aluAddOv;
            end
            controlPkg::stMemRead: iOrD = 1'b1;
            controlPkg::stLoadWrite:
            begin
                regWrite = 1'b1;
                memToReg = controlPkg::mtrMemData;
            end
            controlPkg::stStore:
            begin
                iOrD     = 1'b1;
                memWrite = 1'b1;
            end
            controlPkg::stJump:
            begin
                pcWrite = 1'b1;
                if (latchedClass == controlPkg::clsJal)
                begin
                    regWrite = 1'b1;
                    regDest  = controlPkg::dstReturnAddr;
                    memToReg = controlPkg::mtrPcLink;
                end
            end
            controlPkg::stExceptOverflow, controlPkg::stExceptInvalid:
            begin
                pcWrite  = 1'b1;
                epcWrite = 1'b1;  // Save faulting PC
                pcSource = controlPkg::pcsExceptionVector;
                excCause = (state == controlPkg::stExceptOverflow) ? controlPkg::excOverflow
                                                                   : controlPkg::excInvalid;
            end
            default: ;  // fetchWait keeps idle values
        endcase

        // Register file and memory must never be written in the same state
        regMemExcl: assert (!(regWrite && memWrite))
            else $error("regWrite and memWrite high together");
        pcWrExcl: assert (!(pcWrite && pcWriteCond))
            else $error("pcWrite and pcWriteCond high together");
    end

endmodule

`default_nettype wire

// ==== controlUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module controlUnit #(
    parameter int memWaitCycles = 2  // Memory read latency in cycles
) (
    input  wire                  clk,
    input  wire                  reset,
    input  wire [5:0]            opcode,
    input  wire [5:0]            funct,
    input  wire                  overflowFlag,
    output logic                 pcWrite,
    output logic                 pcWriteCond,
    output logic                 iOrD,
    output logic                 memWrite,
    output logic                 irWrite,
    output logic                 regWrite,
    output logic                 aluSrcA,
    output logic                 epcWrite,
    output controlPkg::regDestT  regDest,
    output controlPkg::memToRegT memToReg,
    output controlPkg::aluSrcBT  aluSrcB,
    output controlPkg::aluOpT    aluControl,
    output controlPkg::pcSourceT pcSource,
    output controlPkg::excCauseT excCause
);

    controlPkg::instrClassT instrClass;
    controlPkg::instrClassT latchedClass;
    controlPkg::stateT      state;

    instrDecoder i_instrDecoder (
        .opcode     (opcode),
        .funct      (funct),
        .instrClass (instrClass)
    );

    stateSequencer #(
        .memWaitCycles (memWaitCycles)
    ) i_stateSequencer (
        .clk          (clk),
        .reset        (reset),
        .instrClass   (instrClass),
        .overflowFlag (overflowFlag),
        .state        (state),
        .latchedClass (latchedClass)
    );

    controlSignalDecode i_controlSignalDecode (
        .state        (state),
        .latchedClass (latchedClass),
        .pcWrite      (pcWrite),
        .pcWriteCond  (pcWriteCond),
        .iOrD         (iOrD),
        .memWrite     (memWrite),
        .irWrite      (irWrite),
        .regWrite     (regWrite),
        .aluSrcA      (aluSrcA),
        .epcWrite     (epcWrite),
        .regDest      (regDest),
        .memToReg     (memToReg),
        .aluSrcB      (aluSrcB),
        .aluControl   (aluControl),
        .pcSource     (pcSource),
        .excCause     (excCause)
    );

endmodule

`default_nettype wire

// ==== tbTasks.svh ====
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

////////////////////
// Output checks
////////////////////

// Compares all control outputs in the current cycle
task automatic checkOutputs(
    input string                name,
    input logic [7:0]           en,
    input controlPkg::regDestT  dst,
    input controlPkg::memToRegT mtr,
    input controlPkg::aluSrcBT  srcB,
    input controlPkg::aluOpT    alu,
    input controlPkg::pcSourceT pcs,
    input controlPkg::excCauseT exc
);
    logic [22:0] expected;
    logic [22:0] actual;
    expected = {en, dst, mtr, srcB, alu, pcs, exc};
    actual   = {pcWrite, pcWriteCond, iOrD, memWrite, irWrite, regWrite, aluSrcA, epcWrite,
                regDest, memToReg, aluSrcB, aluControl, pcSource, excCause};
    checkCount++;
    assert (actual == expected)
    else
    begin
        errorCount++;
        $display("ERROR at %0t ns: %s outputs %h, expected %h", $time, name, actual, expected);
    end
endtask

// Idle fetchWait cycles until irWrite, which must come after memWaitCycles
task automatic expectRefetch();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!irWrite && cycles < waitLimit)
    begin
        checkOutputs("fetchWait", enNone, controlPkg::dstRt, controlPkg::mtrAluOut,
                     controlPkg::srcBRegB, controlPkg::aluLoad, controlPkg::pcsJumpTarget,
                     controlPkg::excNone);
        cycles++;
        @(negedge clk);
    end
    if (!irWrite)
    begin
        timeoutCount++;
        $display("Timeout: irWrite did not rise within %0d cycles", waitLimit);
    end
    else
    begin
        assert (cycles == memWaitCycles)
        else
        begin
            errorCount++;
            $display("ERROR at %0t ns: irWrite after %0d wait cycles, expected %0d",
                     $time, cycles, memWaitCycles);
        end
    end
endtask

// Drives the IR fields, then checks fetchLatch and decode
task automatic issueInstr(input logic [5:0] op, input logic [5:0] fn, input logic ovf);
    @(posedge clk);
    opcode       <= op;
    funct        <= fn;
    overflowFlag <= ovf;
    expectRefetch();
    checkOutputs("fetchLatch", enIrWrite, controlPkg::dstRt, controlPkg::mtrAluOut,
                 controlPkg::srcBFour, controlPkg::aluAddOv, controlPkg::pcsJumpTarget,
                 controlPkg::excNone);
    @(negedge clk);
    checkOutputs("decode", enPcWrite, controlPkg::dstRt, controlPkg::mtrAluOut,
                 controlPkg::srcBRegB, controlPkg::aluLoad, controlPkg::pcsAluOut,
                 controlPkg::excNone);
endtask

////////////////////
// Directed tests
////////////////////
task automatic resetTest();
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    checkOutputs("resetInit", enRegWrite, controlPkg::dstStackPtr, controlPkg::mtrStackInit,
                 controlPkg::srcBRegB, controlPkg::aluLoad, controlPkg::pcsJumpTarget,
                 controlPkg::excNone);
endtask

task automatic arithTest(
    input logic [5:0]        op,
    input logic [5:0]        fn,
    input logic              ovf,
    input controlPkg::aluOpT alu,
    input logic              imm
);
    controlPkg::aluSrcBT srcB;
    controlPkg::regDestT dst;
    logic                trap;
    if (imm)
    begin
        srcB = controlPkg::srcBImm;
        dst  = controlPkg::dstRt;
    end
    else
    begin
        srcB = controlPkg::srcBRegB;
        dst  = controlPkg::dstRd;
    end
    // Only add, addi and sub trap on overflow
    trap = ovf && (alu == controlPkg::aluAddOv || alu == controlPkg::aluSub);
    issueInstr(op, fn, ovf);
    @(negedge clk);
    checkOutputs("aluExec", enAluSrcA, controlPkg::dstRt, controlPkg::mtrAluOut, srcB, alu,
                 controlPkg::pcsJumpTarget, controlPkg::excNone);
    @(negedge clk);
    if (trap)
        checkOutputs("exceptOverflow", enPcWrite | enEpcWrite, controlPkg::dstRt,
                     controlPkg::mtrAluOut, controlPkg::srcBRegB, controlPkg::aluLoad,
                     controlPkg::pcsExceptionVector, controlPkg::excOverflow);
    else
        checkOutputs("writeBack", enRegWrite, dst, controlPkg::mtrAluOut,
                     controlPkg::srcBRegB, controlPkg::aluLoad, controlPkg::pcsJumpTarget,
                     controlPkg::excNone);
endtask

task automatic branchTest(input logic [5:0] op, input controlPkg::aluOpT alu);
    issueInstr(op, 6'h00, 1'b0);
    @(negedge clk);
    checkOutputs("branchTarget", enNone, controlPkg::dstRt, controlPkg::mtrAluOut,
                 controlPkg::srcBBranchOff, controlPkg::aluAddOv, controlPkg::pcsJumpTarget,
                 controlPkg::excNone);
    @(negedge clk);
    checkOutputs("branchCompare", enPcCond, controlPkg::dstRt, controlPkg::mtrAluOut,
                 controlPkg::srcBRegB, alu, controlPkg::pcsAluOut, controlPkg::excNone);
endtask

// Base plus offset, shared by lw and sw
task automatic addrCalcCheck();
    @(negedge clk);
    checkOutputs("addrCalc", enAluSrcA, controlPkg::dstRt, controlPkg::mtrAluOut,
                 controlPkg::srcBImm, controlPkg::aluAddOv, controlPkg::pcsJumpTarget,
                 controlPkg::excNone);
endtask

task automatic loadTest();
    issueInstr(controlPkg::OP_LW, 6'h00, 1'b0);
    addrCalcCheck();
    repeat (memWaitCycles)
    begin
        @(negedge clk);
        checkOutputs("memRead", enIOrD, controlPkg::dstRt, controlPkg::mtrAluOut,
                     controlPkg::srcBRegB, controlPkg::aluLoad, controlPkg::pcsJumpTarget,
                     controlPkg::excNone);
    end
    @(negedge clk);
    checkOutputs("loadWrite", enRegWrite, controlPkg::dstRt, controlPkg::mtrMemData,
                 controlPkg::srcBRegB, controlPkg::aluLoad, controlPkg::pcsJumpTarget,
                 controlPkg::excNone);
endtask

task automatic storeTest();
    issueInstr(controlPkg::OP_SW, 6'h00, 1'b0);
    addrCalcCheck();
    @(negedge clk);
    checkOutputs("store", enIOrD | enMemWrite, controlPkg::dstRt, controlPkg::mtrAluOut,
                 controlPkg::srcBRegB, controlPkg::aluLoad, controlPkg::pcsJumpTarget,
                 controlPkg::excNone);
endtask

task automatic jumpTest(input logic [5:0] op, input logic link);
    issueInstr(op, 6'h00, 1'b0);
    @(negedge clk);
    if (link)
        checkOutputs("jal", enPcWrite | enRegWrite, controlPkg::dstReturnAddr,
                     controlPkg::mtrPcLink, controlPkg::srcBRegB, controlPkg::aluLoad,
                     controlPkg::pcsJumpTarget, controlPkg::excNone);
    else
        checkOutputs("j", enPcWrite, controlPkg::dstRt, controlPkg::mtrAluOut,
                     controlPkg::srcBRegB, controlPkg::aluLoad, controlPkg::pcsJumpTarget,
                     controlPkg::excNone);
endtask

task automatic invalidTest(input logic [5:0] op, input logic [5:0] fn);
    issueInstr(op, fn, 1'b0);
    @(negedge clk);
    checkOutputs("exceptInvalid", enPcWrite | enEpcWrite, controlPkg::dstRt,
                 controlPkg::mtrAluOut, controlPkg::srcBRegB, controlPkg::aluLoad,
                 controlPkg::pcsExceptionVector, controlPkg::excInvalid);
endtask

////////////////////
// Random invalid codes
////////////////////
function automatic logic isKnownCode(input logic [5:0] op, input logic [5:0] fn);
    if (op == controlPkg::OP_RTYPE)
        return fn inside {controlPkg::FN_ADD, controlPkg::FN_SUB, controlPkg::FN_AND,
                          controlPkg::FN_OR, controlPkg::FN_SLT};
    return op inside {controlPkg::OP_ADDI, controlPkg::OP_ADDIU, controlPkg::OP_SLTI,
                      controlPkg::OP_BEQ, controlPkg::OP_BNE, controlPkg::OP_BLE,
                      controlPkg::OP_BGT, controlPkg::OP_LW, controlPkg::OP_SW,
                      controlPkg::OP_J, controlPkg::OP_JAL};
endfunction

// One LFSR step per bit taken
task automatic drawField(output logic [5:0] value);
    value = '0;
    for (int i = 0; i < 6; i++)
    begin
        lfsrState = lfsrNext(lfsrState);
        value     = {value[4:0], lfsrState[0]};
    end
endtask

task automatic randomInvalidTests(input int count);
    logic [5:0] op;
    logic [5:0] fn;
    int         done;
    done = 0;
    for (int tries = 0; tries < 200 && done < count; tries++)
    begin
        drawField(op);
        drawField(fn);
        if (!isKnownCode(op, fn))
        begin
            invalidTest(op, fn);
            done++;
        end
    end
endtask

`endif

// ==== tbControlUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbControlUnit;

    localparam int memWaitCycles = 2;
    localparam int waitLimit     = 20;  // Cycles before a wait gives up

    // Enable bits in output word order
    localparam logic [7:0] enNone     = 8'h00;
    localparam logic [7:0] enPcWrite  = 8'h80;
    localparam logic [7:0] enPcCond   = 8'h40;
    localparam logic [7:0] enIOrD     = 8'h20;
    localparam logic [7:0] enMemWrite = 8'h10;
    localparam logic [7:0] enIrWrite  = 8'h08;
    localparam logic [7:0] enRegWrite = 8'h04;
    localparam logic [7:0] enAluSrcA  = 8'h02;
    localparam logic [7:0] enEpcWrite = 8'h01;

    logic       clk;
    logic       reset;
    logic [5:0] opcode;
    logic [5:0] funct;
    logic       overflowFlag;

    logic                 pcWrite;
    logic                 pcWriteCond;
    logic                 iOrD;
    logic                 memWrite;
    logic                 irWrite;
    logic                 regWrite;
    logic                 aluSrcA;
    logic                 epcWrite;
    controlPkg::regDestT  regDest;
    controlPkg::memToRegT memToReg;
    controlPkg::aluSrcBT  aluSrcB;
    controlPkg::aluOpT    aluControl;
    controlPkg::pcSourceT pcSource;
    controlPkg::excCauseT excCause;

    int          errorCount;
    int          timeoutCount;
    int          checkCount;
    logic [16:0] lfsrState;

    controlUnit #(
        .memWaitCycles (memWaitCycles)
    ) i_dut (
        .clk          (clk),
        .reset        (reset),
        .opcode       (opcode),
        .funct        (funct),
        .overflowFlag (overflowFlag),
        .pcWrite      (pcWrite),
        .pcWriteCond  (pcWriteCond),
        .iOrD         (iOrD),
        .memWrite     (memWrite),
        .irWrite      (irWrite),
        .regWrite     (regWrite),
        .aluSrcA      (aluSrcA),
        .epcWrite     (epcWrite),
        .regDest      (regDest),
        .memToReg     (memToReg),
        .aluSrcB      (aluSrcB),
        .aluControl   (aluControl),
        .pcSource     (pcSource),
        .excCause     (excCause)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    // 17 bit Fibonacci LFSR, taps 17 and 14
    function automatic logic [16:0] lfsrNext(input logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};
    endfunction

    `include "tbTasks.svh"

    ////////////////////
    // Test sequence
    ////////////////////
    initial
    begin
        reset        = 1'b1;
        opcode       = controlPkg::OP_J;
        funct        = 6'h00;
        overflowFlag = 1'b0;
        errorCount   = 0;
        timeoutCount = 0;
        checkCount   = 0;
        lfsrState    = 17'd97583;

        resetTest();
        jumpTest(controlPkg::OP_J, 1'b0);  // Also times the first fetch after reset

        arithTest(controlPkg::OP_RTYPE, controlPkg::FN_ADD, 1'b0, controlPkg::aluAddOv, 1'b0);
        arithTest(controlPkg::OP_RTYPE, controlPkg::FN_SUB, 1'b0, controlPkg::aluSub, 1'b0);
        arithTest(controlPkg::OP_RTYPE, controlPkg::FN_AND, 1'b0, controlPkg::aluAnd, 1'b0);
        arithTest(controlPkg::OP_RTYPE, controlPkg::FN_OR, 1'b0, controlPkg::aluOr, 1'b0);
        arithTest(controlPkg::OP_RTYPE, controlPkg::FN_SLT, 1'b0, controlPkg::aluCmp, 1'b0);

        arithTest(controlPkg::OP_ADDI, 6'h00, 1'b0, controlPkg::aluAddOv, 1'b1);
        arithTest(controlPkg::OP_ADDIU, 6'h00, 1'b0, controlPkg::aluAddNoOv, 1'b1);
        arithTest(controlPkg::OP_SLTI, 6'h00, 1'b0, controlPkg::aluCmp, 1'b1);
        arithTest(controlPkg::OP_RTYPE, controlPkg::FN_ADD, 1'b1, controlPkg::aluAddOv, 1'b0);
        arithTest(controlPkg::OP_ADDI, 6'h00, 1'b1, controlPkg::aluAddOv, 1'b1);
        arithTest(controlPkg::OP_RTYPE, controlPkg::FN_SUB, 1'b1, controlPkg::aluSub, 1'b0);
        arithTest(controlPkg::OP_ADDIU, 6'h00, 1'b1, controlPkg::aluAddNoOv, 1'b1);

        loadTest();
        storeTest();

        branchTest(controlPkg::OP_BEQ, controlPkg::aluEq);
        branchTest(controlPkg::OP_BNE, controlPkg::aluNe);
        branchTest(controlPkg::OP_BLE, controlPkg::aluLe);
        branchTest(controlPkg::OP_BGT, controlPkg::aluGt);
        jumpTest(controlPkg::OP_JAL, 1'b1);

        invalidTest(6'h00, 6'h00);  // R-type shift, not supported
        randomInvalidTests(6);
        expectRefetch();

        $display("Checks: %0d, errors: %0d, timeouts: %0d",
                 checkCount, errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+.
controlPkg.sv
instrDecoder.sv
stateSequencer.sv
controlSignalDecode.sv
controlUnit.sv
tbControlUnit.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the control unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ps --top-module tbControlUnit \
    -f files.f -o simControlUnit \
    && ./obj_dir/simControlUnit | tee /dev/stderr | grep -q "Done: no errors" \
    && echo "Simulation PASSED" \
    || { echo "Simulation FAILED"; exit 1; }
